// File: project.f
rtl/fp_pkg.sv
rtl/fp_rf.sv
rtl/fp_sgnj_unit.sv
rtl/fp_exec_timer.sv
rtl/fp_issue_ctrl.sv
rtl/fp_sgnj_top.sv
tests/tb_clk_gen.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top -f project.f --Mdir obj_dir -o sim
./obj_dir/sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "TESTS PASSED" sim.log

// File: tests/tb_top.sv
module tb_top import fp_pkg::*; ();

  localparam int unsigned FLEN     = 32;
  localparam int unsigned EXEC_LAT = 3;
  // Reset reads, imm, sign injection, latency, back-pressure, random mix
  localparam int unsigned NUM_CMDS = 32 + 32 + 48 + 8 + 12 + 200;
  localparam int unsigned TIMEOUT  = NUM_CMDS * (EXEC_LAT + 10) * 8;

  logic clk_i, rst_ni;
  logic cmd_valid_i, cmd_ready_o, res_valid_o, res_ready_i;
  fp_op_t cmd_op_i;
  freg_idx_t cmd_rd_i, cmd_rs1_i, cmd_rs2_i, res_rd_o, exp_rd;
  logic [FLEN-1:0] cmd_imm_i, res_value_o, exp_val;
  logic [FLEN-1:0] model_rf [FREG_NUM];
  int test_idx, err_cnt, stall_cnt;
  logic test_end, all_done;
  // 0 random, 1 always ready, 2 stall six cycles per result
  logic [1:0] ready_mode;
  integer seed = 28;
  integer ready_seed = 28;

  tb_clk_gen u_clk (.clk_o(clk_i), .rst_no(rst_ni));

  fp_sgnj_top #(.FLEN(FLEN), .EXEC_LAT(EXEC_LAT)) dut_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .cmd_valid_i(cmd_valid_i), .cmd_ready_o(cmd_ready_o), .cmd_op_i(cmd_op_i),
    .cmd_rd_i(cmd_rd_i), .cmd_rs1_i(cmd_rs1_i), .cmd_rs2_i(cmd_rs2_i),
    .cmd_imm_i(cmd_imm_i), .res_valid_o(res_valid_o), .res_ready_i(res_ready_i),
    .res_rd_o(res_rd_o), .res_value_o(res_value_o)
  );

  tb_checker #(.FLEN(FLEN), .EXEC_LAT(EXEC_LAT)) u_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .cmd_valid_i(cmd_valid_i), .cmd_ready_i(cmd_ready_o),
    .res_valid_i(res_valid_o), .res_ready_i(res_ready_i), .res_rd_i(res_rd_o),
    .res_value_i(res_value_o), .exp_rd_i(exp_rd), .exp_value_i(exp_val),
    .test_idx_i(test_idx), .test_end_i(test_end), .all_done_i(all_done), .err_cnt_o(err_cnt)
  );

  function automatic logic [FLEN-1:0] rand_word();
    logic [63:0] w;
    w = {$random(seed), $random(seed)};
    return w[FLEN-1:0];
  endfunction

  // --------------------------------------------------
  // One command, from issue to commit
  // --------------------------------------------------
  task automatic issue(input fp_op_t op, input freg_idx_t rd, rs1, rs2, input logic hold);
    logic [FLEN-1:0] a, b, imm;
    logic wb;
    a = model_rf[rs1];
    b = model_rf[rs2];
    imm = rand_word();
    wb = 1'b1;
    exp_rd = rd;
    case (op)
      OP_LI:     exp_val = imm;
      OP_FSGNJ:  exp_val = {b[FLEN-1], a[FLEN-2:0]};
      OP_FSGNJN: exp_val = {~b[FLEN-1], a[FLEN-2:0]};
      OP_FSGNJX: exp_val = {a[FLEN-1] ^ b[FLEN-1], a[FLEN-2:0]};
      // Read and unknown opcodes report rs1 and leave the file alone
      default: begin
        exp_val = a;
        exp_rd  = rs1;
        wb      = 1'b0;
      end
    endcase
    cmd_op_i = op;
    cmd_rd_i = rd;
    cmd_rs1_i = rs1;
    cmd_rs2_i = rs2;
    cmd_imm_i = imm;
    cmd_valid_i = 1'b1;
    do @(negedge clk_i); while (!cmd_ready_o);
    @(posedge clk_i);
    #1;
    // Either keep a stale request pending or scramble the idle fields
    if (!hold) begin
      cmd_valid_i = 1'b0;
      cmd_rs1_i = freg_idx_t'($random(seed));
      cmd_rs2_i = freg_idx_t'($random(seed));
      cmd_imm_i = rand_word();
    end
    do @(negedge clk_i); while (!(res_valid_o && res_ready_i));
    @(posedge clk_i);
    #1;
    cmd_valid_i = 1'b0;
    if (wb) begin
      model_rf[exp_rd] = exp_val;
    end
  endtask

  task automatic end_test();
    test_end = 1'b1;
    @(posedge clk_i);
    #1;
    test_end = 1'b0;
  endtask

  // Result-side ready, random draw taken every cycle
  initial begin : ready_drive
    int unsigned rnd;
    res_ready_i = 1'b0;
    stall_cnt = 0;
    forever begin
      @(posedge clk_i);
      #1;
      rnd = {$random(ready_seed)} % 3;
      case (ready_mode)
        2'd0: res_ready_i = (rnd != 0);
        2'd1: res_ready_i = 1'b1;
        default: res_ready_i = res_valid_o && (stall_cnt >= 6);
      endcase
      stall_cnt = res_valid_o ? stall_cnt + 1 : 0;
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("Timeout: the DUT stopped finishing commands before the tests ended");
    $display("TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : stimulus
    freg_idx_t rd, rs1, rs2;
    cmd_valid_i = 1'b0;
    cmd_op_i = OP_READ;
    cmd_rd_i = '0;
    cmd_rs1_i = '0;
    cmd_rs2_i = '0;
    cmd_imm_i = '0;
    exp_rd = '0;
    exp_val = '0;
    test_idx = 0;
    test_end = 1'b0;
    all_done = 1'b0;
    ready_mode = 2'd0;
    foreach (model_rf[i]) model_rf[i] = '0;
    wait (rst_ni);
    @(posedge clk_i);
    #1;
    for (int i = 0; i < FREG_NUM; i++) issue(OP_READ, '0, freg_idx_t'(i), '0, 1'b0);
    end_test();
    test_idx = 1;
    repeat (16) begin
      rd = freg_idx_t'($random(seed));
      issue(OP_LI, rd, '0, '0, 1'b0);
      issue(OP_READ, '0, rd, '0, 1'b0);
    end
    end_test();
    test_idx = 2;
    for (int k = 0; k < 24; k++) begin
      rd = freg_idx_t'($random(seed));
      rs1 = freg_idx_t'($random(seed));
      rs2 = (k % 4 == 0) ? rs1 : freg_idx_t'($random(seed));
      issue(fp_op_t'({$random(seed)} % 3 + 1), rd, rs1, rs2, 1'b0);
      issue(OP_READ, '0, rd, '0, 1'b0);
    end
    end_test();
    // Request held high while busy, ready always granted
    test_idx = 3;
    ready_mode = 2'd1;
    repeat (8) begin
      issue(fp_op_t'({$random(seed)} % 5), freg_idx_t'($random(seed)),
            freg_idx_t'($random(seed)), freg_idx_t'($random(seed)), 1'b1);
    end
    end_test();
    test_idx = 4;
    ready_mode = 2'd2;
    repeat (6) begin
      rd = freg_idx_t'($random(seed));
      issue(OP_LI, rd, '0, '0, 1'b1);
      issue(OP_READ, '0, rd, '0, 1'b1);
    end
    end_test();
    test_idx = 5;
    ready_mode = 2'd0;
    repeat (200) begin
      issue(fp_op_t'($random(seed)), freg_idx_t'($random(seed)),
            freg_idx_t'($random(seed)), freg_idx_t'($random(seed)), 1'b0);
    end
    end_test();
    all_done = 1'b1;
    @(negedge clk_i);
    @(posedge clk_i);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tests/tb_checker.sv
module tb_checker import fp_pkg::*; #(
  parameter int unsigned FLEN     = 32,
  parameter int unsigned EXEC_LAT = 3
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            cmd_valid_i,
  input  logic            cmd_ready_i,
  input  logic            res_valid_i,
  input  logic            res_ready_i,
  input  freg_idx_t       res_rd_i,
  input  logic [FLEN-1:0] res_value_i,
  // Expected result of the command being offered
  input  freg_idx_t       exp_rd_i,
  input  logic [FLEN-1:0] exp_value_i,
  input  int              test_idx_i,
  input  logic            test_end_i,
  input  logic            all_done_i,
  output int              err_cnt_o
);

  // One expected rd and value per accepted command
  logic [FREG_IDX_LEN+FLEN-1:0] exp_q [$];
  int checks = 0;
  int errs = 0;
  int t_checks = 0;
  int t_errs = 0;
  int n_tests = 0;
  logic rst_pending = 1'b0;
  logic inflight = 1'b0;
  logic lat_seen = 1'b0;
  int lat_cnt = 0;
  // Result taken at the previous sample
  logic res_taken = 1'b0;
  // Result port state at the previous sample
  logic stall_q = 1'b0;
  logic [FLEN-1:0] hold_val = '0;
  freg_idx_t hold_rd = '0;

  assign err_cnt_o = errs;

  function automatic string test_name(input int idx);
    case (idx)
      0: return "reset";
      1: return "imm_write";
      2: return "sign_inject";
      3: return "latency";
      4: return "backpressure";
      default: return "random_mix";
    endcase
  endfunction

  task automatic check_val(input string what, input logic [FLEN-1:0] exp, act);
    checks++;
    t_checks++;
    if (exp !== act) begin
      errs++;
      t_errs++;
      $display("ERROR %s %s: expected %h actual %h", test_name(test_idx_i), what, exp, act);
    end
  endtask

  task automatic report(input string msg);
    errs++;
    t_errs++;
    $display("%s in test %s", msg, test_name(test_idx_i));
  endtask

  // --------------------------------------------------
  // Sampled mid-cycle where inputs and outputs have settled
  // --------------------------------------------------
  always @(negedge clk_i) begin : watch
    logic [FREG_IDX_LEN+FLEN-1:0] ent;
    if (!rst_ni) begin
      rst_pending = 1'b1;
    end else begin
      if (rst_pending) begin
        rst_pending = 1'b0;
        check_val("cmd_ready_o after reset", FLEN'(1), FLEN'(cmd_ready_i));
        check_val("res_valid_o after reset", FLEN'(0), FLEN'(res_valid_i));
      end
      // Held result must not move under back-pressure
      if (stall_q) begin
        if (!res_valid_i) begin
          report("res_valid_o dropped before the result was taken");
        end
        check_val("stalled res_value_o", hold_val, res_value_i);
        check_val("stalled res_rd_o", FLEN'(hold_rd), FLEN'(res_rd_i));
      end
      stall_q  = res_valid_i && !res_ready_i;
      hold_val = res_value_i;
      hold_rd  = res_rd_i;
      if (inflight) begin
        if (cmd_ready_i) begin
          report("cmd_ready_o went high while a command was still in flight");
        end
        lat_cnt++;
        if (res_valid_i && !lat_seen) begin
          lat_seen = 1'b1;
          check_val("latency", FLEN'(EXEC_LAT), FLEN'(lat_cnt));
        end
      end
      // Back in idle the cycle after the commit edge
      if (res_taken) begin
        check_val("cmd_ready_o after commit", FLEN'(1), FLEN'(cmd_ready_i));
      end
      res_taken = res_valid_i && res_ready_i;
      // Result handshake
      if (res_valid_i && res_ready_i) begin
        if (exp_q.size() == 0) begin
          report("A result was handed out with no command outstanding");
        end else begin
          ent = exp_q.pop_front();
          check_val("res_rd_o", FLEN'(ent[FREG_IDX_LEN+FLEN-1:FLEN]), FLEN'(res_rd_i));
          check_val("res_value_o", ent[FLEN-1:0], res_value_i);
        end
        inflight = 1'b0;
      end
      // Command handshake counts from the accept edge
      if (cmd_valid_i && cmd_ready_i) begin
        exp_q.push_back({exp_rd_i, exp_value_i});
        inflight = 1'b1;
        lat_seen = 1'b0;
        lat_cnt  = -1;
      end
    end
    if (test_end_i) begin
      $display("test %s: %0d checks, %0d errors", test_name(test_idx_i), t_checks, t_errs);
      n_tests++;
      t_checks = 0;
      t_errs   = 0;
    end
    if (all_done_i) begin
      $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errs);
    end
  end

endmodule

// File: tests/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // Period of 8
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for 8 cycles
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// File: rtl/fp_sgnj_top.sv
module fp_sgnj_top import fp_pkg::*; #(
  parameter int unsigned FLEN     = fp_pkg::FLEN,
  parameter int unsigned EXEC_LAT = 3
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  // Command port
  input  logic            cmd_valid_i,
  output logic            cmd_ready_o,
  input  fp_op_t          cmd_op_i,
  input  freg_idx_t       cmd_rd_i,
  input  freg_idx_t       cmd_rs1_i,
  input  freg_idx_t       cmd_rs2_i,
  input  logic [FLEN-1:0] cmd_imm_i,

  // Result port
  output logic            res_valid_o,
  input  logic            res_ready_i,
  output freg_idx_t       res_rd_o,
  output logic [FLEN-1:0] res_value_o
);

  // Control wires
  logic            accept;
  logic            done;
  logic            write_back;
  logic            rf_we;
  // Operand data from the register file
  logic [FLEN-1:0] rs1_data;
  logic [FLEN-1:0] rs2_data;

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------
  fp_rf #(
    .FLEN (FLEN)
  ) u_rf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .we_i       (rf_we),
    .wr_idx_i   (res_rd_o),
    .wr_data_i  (res_value_o),
    .rs1_idx_i  (cmd_rs1_i),
    .rs2_idx_i  (cmd_rs2_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  fp_sgnj_unit #(
    .FLEN (FLEN)
  ) u_sgnj (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .op_i         (cmd_op_i),
    .rd_i         (cmd_rd_i),
    .rs1_i        (cmd_rs1_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .imm_i        (cmd_imm_i),
    .result_o     (res_value_o),
    .res_rd_o     (res_rd_o),
    .write_back_o (write_back)
  );

  // --------------------------------------------------
  // Control
  // --------------------------------------------------
  fp_exec_timer #(
    .EXEC_LAT (EXEC_LAT)
  ) u_timer (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .load_i (accept),
    .done_o (done)
  );

  fp_issue_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .timer_done_i (done),
    .accept_o     (accept),
    .write_back_i (write_back),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .rf_we_o      (rf_we)
  );

endmodule

// File: rtl/fp_issue_ctrl.sv
module fp_issue_ctrl import fp_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  // Command handshake
  input  logic cmd_valid_i,
  output logic cmd_ready_o,

  // Execution timer
  input  logic timer_done_i,
  output logic accept_o,

  // Result handshake and commit
  input  logic write_back_i,
  output logic res_valid_o,
  input  logic res_ready_i,
  output logic rf_we_o
);

  ctrl_state_t state_q, state_d;
  // Result leaves the unit this cycle
  logic        res_hs;

  // --------------------------------------------------
  // Handshakes
  // --------------------------------------------------
  // Only one command in flight
  assign cmd_ready_o = (state_q == S_IDLE);
  assign accept_o    = cmd_valid_i && cmd_ready_o;

  // Result offered only after the latency
  assign res_valid_o = (state_q == S_COMMIT);
  assign res_hs      = res_valid_o && res_ready_i;

  // Commit writes the register file, reads do not
  assign rf_we_o = res_hs && write_back_i;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      S_IDLE: begin
        if (accept_o) begin
          state_d = S_EXEC;
        end
      end
      S_EXEC: begin
        // Wait out the execution latency
        if (timer_done_i) begin
          state_d = S_COMMIT;
        end
      end
      S_COMMIT: begin
        // Hold the result under back-pressure
        if (res_hs) begin
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  // State register
  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: rtl/fp_exec_timer.sv
module fp_exec_timer #(
  parameter int unsigned EXEC_LAT = 3
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic load_i,
  output logic done_o
);

  // Counter wide enough for EXEC_LAT-1, at least one bit
  localparam int unsigned CNT_W = (EXEC_LAT > 1) ? $clog2(EXEC_LAT) : 1;
  localparam logic [CNT_W-1:0] CNT_INIT = CNT_W'(EXEC_LAT - 1);

  logic [CNT_W-1:0] cnt_q;
  // Set by a load, cleared once done has been seen
  logic             armed_q;

  // --------------------------------------------------
  // Down-counter
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : cnt_reg
    if (!rst_ni) begin
      cnt_q   <= '0;
      armed_q <= 1'b0;
    end else if (load_i) begin
      cnt_q   <= CNT_INIT;
      armed_q <= 1'b1;
    end else begin
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // One-cycle done pulse
      if (done_o) begin
        armed_q <= 1'b0;
      end
    end
  end

  // High once the latency has run out
  assign done_o = armed_q && (cnt_q == '0);

endmodule

// File: rtl/fp_sgnj_unit.sv
module fp_sgnj_unit import fp_pkg::*; #(
  parameter int unsigned FLEN = fp_pkg::FLEN
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  // Command capture
  input  logic            accept_i,
  input  fp_op_t          op_i,
  input  freg_idx_t       rd_i,
  input  freg_idx_t       rs1_i,
  input  logic [FLEN-1:0] rs1_data_i,
  input  logic [FLEN-1:0] rs2_data_i,
  input  logic [FLEN-1:0] imm_i,

  // Held result
  output logic [FLEN-1:0] result_o,
  output freg_idx_t       res_rd_o,
  output logic            write_back_o
);

  // Sign bits of both operands
  logic sign1, sign2;
  // Next result, index and write-back flag
  logic [FLEN-1:0] result_d;
  freg_idx_t       rd_d;
  logic            wb_d;

  assign sign1 = rs1_data_i[FLEN-1];
  assign sign2 = rs2_data_i[FLEN-1];

  // --------------------------------------------------
  // Result selection
  // --------------------------------------------------
  always_comb begin : result_sel
    // Read behaviour unless a known opcode overrides it
    result_d = rs1_data_i;
    rd_d     = rs1_i;
    wb_d     = 1'b0;
    unique case (op_i)
      OP_LI: begin
        result_d = imm_i;
        rd_d     = rd_i;
        wb_d     = 1'b1;
      end
      OP_FSGNJ: begin
        result_d = {sign2, rs1_data_i[FLEN-2:0]};
        rd_d     = rd_i;
        wb_d     = 1'b1;
      end
      OP_FSGNJN: begin
        result_d = {~sign2, rs1_data_i[FLEN-2:0]};
        rd_d     = rd_i;
        wb_d     = 1'b1;
      end
      OP_FSGNJX: begin
        result_d = {sign1 ^ sign2, rs1_data_i[FLEN-2:0]};
        rd_d     = rd_i;
        wb_d     = 1'b1;
      end
      default: ;
    endcase
  end

  // Payload held from accept to the next accept
  always_ff @(posedge clk_i) begin : result_reg
    if (accept_i) begin
      result_o <= result_d;
      res_rd_o <= rd_d;
    end
  end

  // No write-back until the first command
  always_ff @(posedge clk_i or negedge rst_ni) begin : wb_reg
    if (!rst_ni) begin
      write_back_o <= 1'b0;
    end else if (accept_i) begin
      write_back_o <= wb_d;
    end
  end

endmodule

// File: rtl/fp_rf.sv
module fp_rf import fp_pkg::*; #(
  parameter int unsigned FLEN = fp_pkg::FLEN
) (
  input  logic            clk_i,
  input  logic            rst_ni,

  // Write port, driven at commit
  input  logic            we_i,
  input  freg_idx_t       wr_idx_i,
  input  logic [FLEN-1:0] wr_data_i,

  // Operand read ports
  input  freg_idx_t       rs1_idx_i,
  input  freg_idx_t       rs2_idx_i,
  output logic [FLEN-1:0] rs1_data_o,
  output logic [FLEN-1:0] rs2_data_o
);

  // Register storage
  logic [FLEN-1:0] regs_q [FREG_NUM];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------
  // All registers read zero after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin : write_port
    if (!rst_ni) begin
      for (int i = 0; i < FREG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // --------------------------------------------------
  // Read ports
  // --------------------------------------------------
  // Combinational, new data seen the cycle after a write
  always_comb begin : read_ports
    rs1_data_o = regs_q[rs1_idx_i];
    rs2_data_o = regs_q[rs2_idx_i];
  end

endmodule

// File: rtl/fp_pkg.sv
package fp_pkg;

  // --------------------------------------------------
  // Register file geometry
  // --------------------------------------------------
  // Default register width, overridden per instance
  localparam int unsigned FLEN = 32;

  localparam int unsigned FREG_NUM = 32;
  localparam int unsigned FREG_IDX_LEN = $clog2(FREG_NUM);

  // Register index
  typedef logic [FREG_IDX_LEN-1:0] freg_idx_t;

  // --------------------------------------------------
  // Command opcodes
  // --------------------------------------------------
  typedef logic [2:0] fp_op_t;

  localparam fp_op_t OP_LI     = 3'd0;
  localparam fp_op_t OP_FSGNJ  = 3'd1;
  localparam fp_op_t OP_FSGNJN = 3'd2;
  localparam fp_op_t OP_FSGNJX = 3'd3;
  localparam fp_op_t OP_READ   = 3'd4;

  // Issue controller states
  typedef enum logic [1:0] {
    S_IDLE,
    S_EXEC,
    S_COMMIT
  } ctrl_state_t;

endpackage
